//--- verif/port_vectors.txt
// port opcode address length first_byte rank
// opcode 1 is write, 0 is read, four lines per group in port order
00000000 00000001 00000010 00000004 00000010 00000000
00000001 00000001 00000020 00000008 000000a0 00000001
00000002 00000001 00000040 00000003 00000033 00000002
00000003 00000001 00000060 00000001 000000c7 00000003
00000000 00000000 00000020 00000008 00000000 00000000
00000001 00000000 00000010 00000004 00000000 00000001
00000002 00000001 00000080 00000005 000000e0 00000002
00000003 00000000 00000040 00000003 00000000 00000003
00000000 00000001 00000090 00000002 0000005b 00000000
00000001 00000000 00000080 00000005 00000000 00000001
00000002 00000000 00000060 00000001 00000000 00000002
00000003 00000000 00000090 00000002 00000000 00000003

//--- src.f
src/xbar_pkg.sv
src/rr_cmd_arbiter.sv
src/wr_path_mux.sv
src/rd_path_demux.sv
src/port_interconnect.sv
verif/tb_port_interconnect.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass message
verilator --binary --timing -f src.f --top-module tb_port_interconnect -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/tb_port_interconnect.sv
// --------------------------------------------------------------------------
// testbench for the four-port interconnect, port clients and memory model
// --------------------------------------------------------------------------
`timescale 1ns/10ps
module tb_port_interconnect;
    import xbar_pkg::*;

    localparam int NUM_VEC   = 12;
    localparam int NUM_FLD   = 6;
    localparam int MAX_BURST = 8;
    localparam int LIMIT     = NUM_VEC * (NUM_PORTS + MAX_BURST + 20);

    logic                 m0;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] cmd_vld;
    mem_cmd_e             cmd [NUM_PORTS];
    logic [ADDR_W-1:0]    addr [NUM_PORTS];
    logic [LEN_W-1:0]     burst_len [NUM_PORTS];
    logic [NUM_PORTS-1:0] cmd_ready;
    logic [NUM_PORTS-1:0] finish;
    logic [NUM_PORTS-1:0] wr_vld;
    logic [DATA_W-1:0]    wr_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] wr_last;
    logic [NUM_PORTS-1:0] wr_ready;
    logic [NUM_PORTS-1:0] rd_vld;
    logic [DATA_W-1:0]    rd_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] rd_last;
    logic [NUM_PORTS-1:0] rd_ready;
    logic                 mem_cmd_vld;
    mem_cmd_e             mem_cmd;
    logic [ADDR_W-1:0]    mem_addr;
    logic [LEN_W-1:0]     mem_burst_len;
    logic                 mem_cmd_ready;
    logic                 mem_finish;
    logic                 mem_wr_vld;
    logic [DATA_W-1:0]    mem_wr_data;
    logic                 mem_wr_last;
    logic                 mem_wr_ready;
    logic                 mem_rd_vld;
    logic [DATA_W-1:0]    mem_rd_data;
    logic                 mem_rd_last;
    logic                 mem_rd_ready;

    logic [31:0] vec_mem [NUM_VEC*NUM_FLD];
    int          exp_order [NUM_VEC];
    logic [7:0]  mem_bytes [256];
    logic [7:0]  ref_mem [256];
    logic [31:0] lcg_state = 32'd32;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          cycles = 0;
    int          owner = -1;
    logic        exec_open = 1'b0;
    int          fin_port = -1;
    int          cr_count [NUM_PORTS];

    port_interconnect dut (.*);

    always #20 m0 = ~m0;

    function automatic logic [31:0] field(input int v, input int k);
        return vec_mem[v*NUM_FLD+k];
    endfunction

    // lcg, ready high three cycles out of four
    function automatic logic stall_free();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30] | lcg_state[29];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // ----------------------------------------------------------------------
    // client side of one port for one vector
    // ----------------------------------------------------------------------
    task automatic run_client(input int v);
        int         p;
        int         len;
        int         i;
        logic       is_wr;
        logic [7:0] first;
        logic [7:0] idx;
        p     = int'(field(v, 0));
        is_wr = (field(v, 1) != 32'd0);
        len   = int'(field(v, 3));
        first = 8'(field(v, 4));
        idx   = 8'(field(v, 2));
        cmd[p]       = is_wr ? CMD_WRITE : CMD_READ;
        addr[p]      = field(v, 2);
        burst_len[p] = LEN_W'(field(v, 3));
        cmd_vld[p]   = 1'b1;
        do @(posedge m0); while (!cmd_ready[p]);
        #1 cmd_vld[p] = 1'b0;
        i = 0;
        if (is_wr) begin
            wr_vld[p]  = 1'b1;
            wr_data[p] = first;
            wr_last[p] = (len == 1);
            while (i < len) begin
                @(posedge m0);
                if (wr_ready[p]) begin
                    ref_mem[idx+8'(i)] = wr_data[p];
                    i++;
                end
                #1;
                if (i < len) begin
                    wr_data[p] = first + 8'(i);
                    wr_last[p] = (i == len - 1);
                end else begin
                    wr_vld[p]  = 1'b0;
                    wr_last[p] = 1'b0;
                end
            end
        end else begin
            rd_ready[p] = stall_free();
            while (i < len) begin
                @(posedge m0);
                if (rd_vld[p] && rd_ready[p]) begin
                    check_value("rd_data", 32'(rd_data[p]), 32'(ref_mem[idx+8'(i)]));
                    check_value("rd_last", 32'(rd_last[p]), 32'(i == len - 1));
                    i++;
                end
                #1 rd_ready[p] = (i < len) ? stall_free() : 1'b0;
            end
        end
        do @(posedge m0); while (!finish[p]);
    endtask

    // one port's vectors in file order, next command right after finish
    task automatic issue_port_vectors(input int p);
        for (int g = 0; g < NUM_VEC / NUM_PORTS; g++) begin
            run_client(g * NUM_PORTS + p);
            #1;
        end
    endtask

    // ----------------------------------------------------------------------
    // memory model, serves one command in the expected order
    // ----------------------------------------------------------------------
    task automatic serve(input int v);
        int         p;
        int         len;
        int         i;
        logic       is_wr;
        logic       accepted;
        logic [7:0] idx;
        p        = int'(field(v, 0));
        is_wr    = (field(v, 1) != 32'd0);
        len      = int'(field(v, 3));
        idx      = 8'(field(v, 2));
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge m0);
            if (mem_cmd_vld) begin
                // fields must hold steady through any stall
                check_value("mem_cmd", 32'(mem_cmd), field(v, 1));
                check_value("mem_addr", mem_addr, field(v, 2));
                check_value("mem_burst_len", 32'(mem_burst_len), field(v, 3));
                accepted = mem_cmd_ready;
            end
            #1 mem_cmd_ready = accepted ? 1'b0 : stall_free();
        end
        owner     = p;
        exec_open = 1'b1;
        i = 0;
        if (is_wr) begin
            mem_wr_ready = stall_free();
            while (i < len) begin
                @(posedge m0);
                if (mem_wr_vld && mem_wr_ready) begin
                    check_value("mem_wr_data", 32'(mem_wr_data),
                                32'(8'(field(v, 4)) + 8'(i)));
                    check_value("mem_wr_last", 32'(mem_wr_last), 32'(i == len - 1));
                    mem_bytes[idx+8'(i)] = mem_wr_data;
                    i++;
                end
                #1 mem_wr_ready = (i < len) ? stall_free() : 1'b0;
            end
        end else begin
            mem_rd_vld  = 1'b1;
            mem_rd_data = mem_bytes[idx];
            mem_rd_last = (len == 1);
            while (i < len) begin
                @(posedge m0);
                if (mem_rd_ready) begin
                    i++;
                end
                #1;
                if (i < len) begin
                    mem_rd_data = mem_bytes[idx+8'(i)];
                    mem_rd_last = (i == len - 1);
                end else begin
                    mem_rd_vld  = 1'b0;
                    mem_rd_last = 1'b0;
                end
            end
        end
        mem_finish = 1'b1;
        @(posedge m0);
        #1 mem_finish = 1'b0;
        exec_open = 1'b0;
        fin_port  = p;
    endtask

    initial begin
        wait (rst_n);
        for (int n = 0; n < NUM_VEC; n++) begin
            serve(exp_order[n]);
        end
    end

    // ----------------------------------------------------------------------
    // per-cycle protocol monitor and timeout
    // ----------------------------------------------------------------------
    always @(posedge m0) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, transactions did not complete", cycles);
            $display("TEST FAIL");
            $finish;
        end else if (rst_n) begin
            if (finish != ((fin_port >= 0) ? NUM_PORTS'(1 << fin_port) : '0)) begin
                $display("finish pulse on the wrong port or cycle, saw %h", finish);
                proto_errs++;
            end
            fin_port = -1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!(exec_open && owner == p) && (wr_ready[p] || rd_vld[p])) begin
                    $display("port %0d saw stream traffic without a grant", p);
                    proto_errs++;
                end
                cr_count[p] += int'(cmd_ready[p]);
            end
        end
    end

    initial begin
        m0            = 1'b0;
        rst_n         = 1'b0;
        cmd_vld       = '0;
        wr_vld        = '0;
        wr_last       = '0;
        rd_ready      = '0;
        mem_cmd_ready = 1'b0;
        mem_finish    = 1'b0;
        mem_wr_ready  = 1'b0;
        mem_rd_vld    = 1'b0;
        mem_rd_data   = '0;
        mem_rd_last   = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            cmd[p]       = CMD_READ;
            addr[p]      = '0;
            burst_len[p] = '0;
            wr_data[p]   = '0;
            cr_count[p]  = 0;
        end
        for (int a = 0; a < 256; a++) begin
            mem_bytes[a] = 8'(a) ^ 8'h5a;
            ref_mem[a]   = 8'(a) ^ 8'h5a;
        end
        $readmemh("verif/port_vectors.txt", vec_mem);
        for (int v = 0; v < NUM_VEC; v++) begin
            exp_order[(v / NUM_PORTS) * NUM_PORTS + int'(field(v, 5))] = v;
        end
        repeat (5) @(posedge m0);
        #1 rst_n = 1'b1;
        @(posedge m0);
        check_value("mem_cmd_vld", 32'(mem_cmd_vld), 32'd0);
        check_value("cmd_ready", 32'(cmd_ready), 32'd0);
        check_value("finish", 32'(finish), 32'd0);
        check_value("rd_vld", 32'(rd_vld), 32'd0);
        check_value("wr_ready", 32'(wr_ready), 32'd0);
        check_value("mem_wr_vld", 32'(mem_wr_vld), 32'd0);
        check_value("mem_rd_ready", 32'(mem_rd_ready), 32'd0);
        #1;
        // every port runs its own vectors, all request together
        fork
            issue_port_vectors(0);
            issue_port_vectors(1);
            issue_port_vectors(2);
            issue_port_vectors(3);
        join
        repeat (3) @(posedge m0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value("cmd_ready count", 32'(cr_count[p]), 32'(NUM_VEC / NUM_PORTS));
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- src/port_interconnect.sv
// --------------------------------------------------------------------------
// four-port command interconnect, client ports share one memory master
// --------------------------------------------------------------------------
`timescale 1ns/10ps
module port_interconnect (
    input  logic                             m0,
    input  logic                             rst_n,
    // client command ports
    input  logic [xbar_pkg::NUM_PORTS-1:0]   cmd_vld,
    input  xbar_pkg::mem_cmd_e               cmd [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::ADDR_W-1:0]      addr [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::LEN_W-1:0]       burst_len [xbar_pkg::NUM_PORTS],
    output logic [xbar_pkg::NUM_PORTS-1:0]   cmd_ready,
    output logic [xbar_pkg::NUM_PORTS-1:0]   finish,
    // client write streams
    input  logic [xbar_pkg::NUM_PORTS-1:0]   wr_vld,
    input  logic [xbar_pkg::DATA_W-1:0]      wr_data [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::NUM_PORTS-1:0]   wr_last,
    output logic [xbar_pkg::NUM_PORTS-1:0]   wr_ready,
    // client read streams
    output logic [xbar_pkg::NUM_PORTS-1:0]   rd_vld,
    output logic [xbar_pkg::DATA_W-1:0]      rd_data [xbar_pkg::NUM_PORTS],
    output logic [xbar_pkg::NUM_PORTS-1:0]   rd_last,
    input  logic [xbar_pkg::NUM_PORTS-1:0]   rd_ready,
    // memory command
    output logic                             mem_cmd_vld,
    output xbar_pkg::mem_cmd_e               mem_cmd,
    output logic [xbar_pkg::ADDR_W-1:0]      mem_addr,
    output logic [xbar_pkg::LEN_W-1:0]       mem_burst_len,
    input  logic                             mem_cmd_ready,
    input  logic                             mem_finish,
    // memory write stream
    output logic                             mem_wr_vld,
    output logic [xbar_pkg::DATA_W-1:0]      mem_wr_data,
    output logic                             mem_wr_last,
    input  logic                             mem_wr_ready,
    // memory read stream
    input  logic                             mem_rd_vld,
    input  logic [xbar_pkg::DATA_W-1:0]      mem_rd_data,
    input  logic                             mem_rd_last,
    output logic                             mem_rd_ready
);
    import xbar_pkg::*;

    // grant from the arbiter, both data paths follow it
    logic [PORT_W-1:0] grant_port;
    logic              path_vld;

    // ---------------------------------------------------------------------
    // command arbiter
    // ---------------------------------------------------------------------
    rr_cmd_arbiter u_arb (
        .m0            (m0),
        .rst_n         (rst_n),
        .cmd_vld       (cmd_vld),
        .cmd           (cmd),
        .addr          (addr),
        .burst_len     (burst_len),
        .cmd_ready     (cmd_ready),
        .finish        (finish),
        .mem_cmd_vld   (mem_cmd_vld),
        .mem_cmd       (mem_cmd),
        .mem_addr      (mem_addr),
        .mem_burst_len (mem_burst_len),
        .mem_cmd_ready (mem_cmd_ready),
        .mem_finish    (mem_finish),
        .grant_port    (grant_port),
        .path_vld      (path_vld)
    );

    // ---------------------------------------------------------------------
    // data paths
    // ---------------------------------------------------------------------
    wr_path_mux u_wr (
        .grant_port   (grant_port),
        .path_vld     (path_vld),
        .wr_vld       (wr_vld),
        .wr_last      (wr_last),
        .wr_data      (wr_data),
        .wr_ready     (wr_ready),
        .mem_wr_vld   (mem_wr_vld),
        .mem_wr_data  (mem_wr_data),
        .mem_wr_last  (mem_wr_last),
        .mem_wr_ready (mem_wr_ready)
    );

    rd_path_demux u_rd (
        .grant_port   (grant_port),
        .path_vld     (path_vld),
        .mem_rd_vld   (mem_rd_vld),
        .mem_rd_data  (mem_rd_data),
        .mem_rd_last  (mem_rd_last),
        .mem_rd_ready (mem_rd_ready),
        .rd_vld       (rd_vld),
        .rd_last      (rd_last),
        .rd_data      (rd_data),
        .rd_ready     (rd_ready)
    );

endmodule

//--- src/rd_path_demux.sv
// --------------------------------------------------------------------------
// read stream demux, memory beats steered to the granted port
// --------------------------------------------------------------------------
`timescale 1ns/10ps
module rd_path_demux (
    input  logic [xbar_pkg::PORT_W-1:0]      grant_port,
    input  logic                             path_vld,
    input  logic                             mem_rd_vld,
    input  logic [xbar_pkg::DATA_W-1:0]      mem_rd_data,
    input  logic                             mem_rd_last,
    output logic                             mem_rd_ready,
    output logic [xbar_pkg::NUM_PORTS-1:0]   rd_vld,
    output logic [xbar_pkg::NUM_PORTS-1:0]   rd_last,
    output logic [xbar_pkg::DATA_W-1:0]      rd_data [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::NUM_PORTS-1:0]   rd_ready
);
    import xbar_pkg::*;

    logic [NUM_PORTS-1:0] sel;

    // one-hot port select, empty while the path is closed
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            sel[i] = path_vld && (grant_port == PORT_W'(i));
        end
    end

    // ---------------------------------------------------------------------
    // per-port outputs
    // ---------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            rd_vld[i]  = sel[i] && mem_rd_vld;
            rd_last[i] = sel[i] && mem_rd_last;
            // data lines are shared, valid qualifies them
            rd_data[i] = mem_rd_data;
        end
    end

    // owner's ready goes back to memory
    assign mem_rd_ready = |(sel & rd_ready);

endmodule

//--- src/wr_path_mux.sv
// --------------------------------------------------------------------------
// write stream mux, granted port onto the memory side while the path is open
// --------------------------------------------------------------------------
`timescale 1ns/10ps
module wr_path_mux (
    input  logic [xbar_pkg::PORT_W-1:0]      grant_port,
    input  logic                             path_vld,
    input  logic [xbar_pkg::NUM_PORTS-1:0]   wr_vld,
    input  logic [xbar_pkg::NUM_PORTS-1:0]   wr_last,
    input  logic [xbar_pkg::DATA_W-1:0]      wr_data [xbar_pkg::NUM_PORTS],
    output logic [xbar_pkg::NUM_PORTS-1:0]   wr_ready,
    output logic                             mem_wr_vld,
    output logic [xbar_pkg::DATA_W-1:0]      mem_wr_data,
    output logic                             mem_wr_last,
    input  logic                             mem_wr_ready
);
    import xbar_pkg::*;

    // ---------------------------------------------------------------------
    // forward path
    // ---------------------------------------------------------------------
    // data follows the grant, valid and last only while open
    assign mem_wr_data = wr_data[grant_port];
    assign mem_wr_vld  = path_vld && wr_vld[grant_port];
    assign mem_wr_last = path_vld && wr_last[grant_port];

    // ---------------------------------------------------------------------
    // ready back to the owner only
    // ---------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            wr_ready[i] = path_vld && (grant_port == PORT_W'(i)) && mem_wr_ready;
        end
    end

endmodule

//--- src/rr_cmd_arbiter.sv
// --------------------------------------------------------------------------
// round-robin command arbiter, owns the memory-side command and the grant
// --------------------------------------------------------------------------
`timescale 1ns/10ps
module rr_cmd_arbiter (
    input  logic                             m0,
    input  logic                             rst_n,
    input  logic [xbar_pkg::NUM_PORTS-1:0]   cmd_vld,
    input  xbar_pkg::mem_cmd_e               cmd [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::ADDR_W-1:0]      addr [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::LEN_W-1:0]       burst_len [xbar_pkg::NUM_PORTS],
    output logic [xbar_pkg::NUM_PORTS-1:0]   cmd_ready,
    output logic [xbar_pkg::NUM_PORTS-1:0]   finish,
    output logic                             mem_cmd_vld,
    output xbar_pkg::mem_cmd_e               mem_cmd,
    output logic [xbar_pkg::ADDR_W-1:0]      mem_addr,
    output logic [xbar_pkg::LEN_W-1:0]       mem_burst_len,
    input  logic                             mem_cmd_ready,
    input  logic                             mem_finish,
    output logic [xbar_pkg::PORT_W-1:0]      grant_port,
    output logic                             path_vld
);
    import xbar_pkg::*;

    arb_state_e          state;
    arb_state_e          state_nxt;
    logic [PORT_W-1:0]   scan_ptr;
    logic [PORT_W-1:0]   ptr_inc;
    logic                hit;

    // pending command on the port under the pointer
    assign hit     = (state == ARB_SCAN) && cmd_vld[scan_ptr];
    assign ptr_inc = (scan_ptr == PORT_W'(NUM_PORTS - 1)) ? '0 : scan_ptr + 1'b1;

    // ---------------------------------------------------------------------
    // scan fsm
    // ---------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: state_nxt = ARB_SCAN;
            ARB_SCAN: begin
                if (hit) begin
                    state_nxt = ARB_REQ;
                end
            end
            ARB_REQ: begin
                if (mem_cmd_vld && mem_cmd_ready) begin
                    state_nxt = ARB_EXEC;
                end
            end
            ARB_EXEC: begin
                if (mem_finish) begin
                    state_nxt = ARB_DONE;
                end
            end
            ARB_DONE: state_nxt = ARB_SCAN;
            default:  state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // pointer steps on a miss, and past the owner once it is finished
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            scan_ptr <= '0;
        end else if ((state == ARB_SCAN && !hit) || state == ARB_DONE) begin
            scan_ptr <= ptr_inc;
        end
    end

    // ---------------------------------------------------------------------
    // command capture and strobes
    // ---------------------------------------------------------------------
    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            mem_cmd_vld <= 1'b0;
        end else if (hit) begin
            mem_cmd_vld <= 1'b1;
        end else if (mem_cmd_ready) begin
            mem_cmd_vld <= 1'b0;
        end
    end

    always_ff @(posedge m0) begin
        if (hit) begin
            mem_cmd       <= cmd[scan_ptr];
            mem_addr      <= addr[scan_ptr];
            mem_burst_len <= burst_len[scan_ptr];
        end
    end

    always_ff @(posedge m0 or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ready <= '0;
            finish    <= '0;
        end else begin
            cmd_ready <= '0;
            finish    <= '0;
            if (hit) begin
                cmd_ready[scan_ptr] <= 1'b1;
            end
            if (state == ARB_EXEC && mem_finish) begin
                finish[scan_ptr] <= 1'b1;
            end
        end
    end

    // pointer stays on the owner from capture to done
    assign grant_port = scan_ptr;
    assign path_vld   = (state == ARB_EXEC);

endmodule

//--- src/xbar_pkg.sv
// --------------------------------------------------------------------------
// shared sizes and types for the four-port command interconnect
// --------------------------------------------------------------------------
package xbar_pkg;

    // ---------------------------------------------------------------------
    // sizes
    // ---------------------------------------------------------------------
    localparam int NUM_PORTS = 4;
    localparam int PORT_W    = 2;
    localparam int ADDR_W    = 32;
    // one beat on either data stream
    localparam int DATA_W    = 8;
    // burst length in beats
    localparam int LEN_W     = 24;

    // ---------------------------------------------------------------------
    // types
    // ---------------------------------------------------------------------
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } mem_cmd_e;

    // scan visits one port per cycle, exec covers the data phase
    typedef enum logic [2:0] {
        ARB_IDLE = 3'd0,
        ARB_SCAN = 3'd1,
        ARB_REQ  = 3'd2,
        ARB_EXEC = 3'd3,
        ARB_DONE = 3'd4
    } arb_state_e;

endpackage
